// File: frame_pkg.sv
package frame_pkg;

    // Owner of a screen pixel.
    typedef enum logic [1:0] {
        OBJ_MAP  = 2'd0,
        OBJ_CAR1 = 2'd1,
        OBJ_CAR2 = 2'd2
    } object_id_t;

    // Car sprites are square.
    localparam int SPRITE_SIZE = 8;
    localparam int SPRITE_PIX  = SPRITE_SIZE * SPRITE_SIZE;

    // One map colour per 8x8 screen block.
    localparam int TILE_SHIFT = 3;

    localparam int COLOR_IDX_W = 4;
    localparam int COLOR_W     = 24;

    // Four colour indices per word, nibble 0 in the low bits.
    localparam int SRAM_DATA_W = 16;
    localparam int SRAM_ADDR_W = 12;
    localparam int SEL_W       = $clog2(SRAM_DATA_W / COLOR_IDX_W);

    // Word bases of the stored images.
    localparam int MAP_BASE  = 0;
    localparam int CAR1_BASE = 1024;
    localparam int CAR2_BASE = 1040;

    localparam int PIX_IDX_W = 10;
    localparam int COORD_W   = 10;

endpackage

// File: delay_line.sv
`timescale 1ns/1ps

module delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  T     i_d,
    output T     o_q
);

    T stage [DEPTH];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= T'(0);
            end
        end else begin
            stage[0] <= i_d;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign o_q = stage[DEPTH-1];

endmodule

// File: scan_timing.sv
`timescale 1ns/1ps

module scan_timing
    import frame_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_TOTAL  = 800,
    parameter int V_ACTIVE = 480,
    parameter int V_TOTAL  = 525,
    parameter int SYNC_LEN = 96
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    output logic [COORD_W-1:0] o_h_count,
    output logic [COORD_W-1:0] o_v_count,
    output logic               o_active,
    output logic               o_hsync,
    output logic               o_vsync
);

    localparam logic [COORD_W-1:0] H_ACT_C  = COORD_W'(H_ACTIVE);
    localparam logic [COORD_W-1:0] H_LAST_C = COORD_W'(H_TOTAL - 1);
    localparam logic [COORD_W-1:0] H_SEND_C = COORD_W'(H_ACTIVE + SYNC_LEN);
    localparam logic [COORD_W-1:0] V_ACT_C  = COORD_W'(V_ACTIVE);
    localparam logic [COORD_W-1:0] V_LAST_C = COORD_W'(V_TOTAL - 1);

    logic h_last;
    logic v_last;

    assign h_last = (o_h_count == H_LAST_C);
    assign v_last = (o_v_count == V_LAST_C);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_h_count <= '0;
            o_v_count <= '0;
        end else if (h_last) begin
            o_h_count <= '0;
            o_v_count <= v_last ? '0 : o_v_count + 1'b1;
        end else begin
            o_h_count <= o_h_count + 1'b1;
        end
    end

    assign o_active = (o_h_count < H_ACT_C) && (o_v_count < V_ACT_C);
    // Sync pulse starts right after the visible part of the line.
    assign o_hsync  = (o_h_count >= H_ACT_C) && (o_h_count < H_SEND_C);
    assign o_vsync  = (o_v_count == V_ACT_C);

    a_h_wrap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_h_count <= H_LAST_C);

endmodule

// File: pixel_decoder.sv
`timescale 1ns/1ps

module pixel_decoder
    import frame_pkg::*;
#(
    parameter int H_ACTIVE = 640
) (
    input  logic [COORD_W-1:0]        i_h_count,
    input  logic [COORD_W-1:0]        i_v_count,
    input  logic signed [COORD_W-1:0] i_car1_x,
    input  logic signed [COORD_W-1:0] i_car1_y,
    input  logic signed [COORD_W-1:0] i_car2_x,
    input  logic signed [COORD_W-1:0] i_car2_y,
    input  logic [SPRITE_PIX-1:0]     i_car1_mask,
    input  logic [SPRITE_PIX-1:0]     i_car2_mask,
    output object_id_t                o_object,
    output logic [PIX_IDX_W-1:0]      o_pixel_index
);

    localparam int SPR_W    = $clog2(SPRITE_SIZE);
    localparam int MAP_COLS = H_ACTIVE >> TILE_SHIFT;

    logic signed [COORD_W:0] car1_dx;
    logic signed [COORD_W:0] car1_dy;
    logic signed [COORD_W:0] car2_dx;
    logic signed [COORD_W:0] car2_dy;
    logic [2*SPR_W-1:0]      car1_local;
    logic [2*SPR_W-1:0]      car2_local;
    logic                    car1_box;
    logic                    car2_box;
    logic                    car1_hit;
    logic                    car2_hit;
    logic [PIX_IDX_W-1:0]    map_index;

    // Scan position relative to a sprite origin, one bit wider.
    function automatic logic signed [COORD_W:0] offset(
        input logic [COORD_W-1:0]        scan,
        input logic signed [COORD_W-1:0] pos
    );
        return $signed({1'b0, scan}) - $signed({pos[COORD_W-1], pos});
    endfunction

    function automatic logic in_sprite(input logic signed [COORD_W:0] d);
        return !d[COORD_W] && (d < (COORD_W + 1)'(SPRITE_SIZE));
    endfunction

    // Box test on plain integers.
    function automatic logic inside_box(
        input logic [COORD_W-1:0]        scan,
        input logic signed [COORD_W-1:0] pos
    );
        return (int'(scan) >= int'(pos)) && (int'(scan) < int'(pos) + SPRITE_SIZE);
    endfunction

    assign car1_dx = offset(i_h_count, i_car1_x);
    assign car1_dy = offset(i_v_count, i_car1_y);
    assign car2_dx = offset(i_h_count, i_car2_x);
    assign car2_dy = offset(i_v_count, i_car2_y);

    // Row times 8 plus column.
    assign car1_local = {car1_dy[SPR_W-1:0], car1_dx[SPR_W-1:0]};
    assign car2_local = {car2_dy[SPR_W-1:0], car2_dx[SPR_W-1:0]};

    assign car1_box = in_sprite(car1_dx) && in_sprite(car1_dy);
    assign car2_box = in_sprite(car2_dx) && in_sprite(car2_dy);

    // Mask bit set means transparent.
    assign car1_hit = car1_box && !i_car1_mask[car1_local];
    assign car2_hit = car2_box && !i_car2_mask[car2_local];

    assign map_index = PIX_IDX_W'(32'(i_v_count >> TILE_SHIFT) * MAP_COLS
                                  + 32'(i_h_count >> TILE_SHIFT));

    always_comb begin
        if (car1_hit) begin
            o_object      = OBJ_CAR1;
            o_pixel_index = PIX_IDX_W'(car1_local);
        end else if (car2_hit) begin
            o_object      = OBJ_CAR2;
            o_pixel_index = PIX_IDX_W'(car2_local);
        end else begin
            o_object      = OBJ_MAP;
            o_pixel_index = map_index;
        end
    end

    // A car owner implies the scan position lies in that car's box.
    always_comb begin
        if (o_object == OBJ_CAR1) begin
            a_car1_box: assert (inside_box(i_h_count, i_car1_x)
                                && inside_box(i_v_count, i_car1_y));
        end
        if (o_object == OBJ_CAR2) begin
            a_car2_box: assert (inside_box(i_h_count, i_car2_x)
                                && inside_box(i_v_count, i_car2_y));
        end
    end

endmodule

// File: sram_addr_encoder.sv
`timescale 1ns/1ps

module sram_addr_encoder
    import frame_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  object_id_t             i_object,
    input  logic [PIX_IDX_W-1:0]   i_pixel_index,
    output logic [SRAM_ADDR_W-1:0] o_sram_addr
);

    // End of the last car image in words.
    localparam logic [SRAM_ADDR_W-1:0] ADDR_END =
        SRAM_ADDR_W'(CAR2_BASE + (SPRITE_PIX >> SEL_W));

    logic [SRAM_ADDR_W-1:0] base;
    logic [SRAM_ADDR_W-1:0] word_index;

    always_comb begin
        case (i_object)
            OBJ_CAR1: base = SRAM_ADDR_W'(CAR1_BASE);
            OBJ_CAR2: base = SRAM_ADDR_W'(CAR2_BASE);
            default:  base = SRAM_ADDR_W'(MAP_BASE);
        endcase
    end

    // Low index bits pick the nibble later.
    assign word_index = SRAM_ADDR_W'(i_pixel_index >> SEL_W);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_sram_addr <= '0;
        end else begin
            o_sram_addr <= base + word_index;
        end
    end

    a_addr_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_sram_addr < ADDR_END);

endmodule

// File: sram_data_decoder.sv
`timescale 1ns/1ps

module sram_data_decoder
    import frame_pkg::*;
(
    input  logic [SRAM_DATA_W-1:0] i_sram_data,
    input  logic [SEL_W-1:0]       i_sel,
    output logic [COLOR_IDX_W-1:0] o_color_idx
);

    localparam int NIBBLES = SRAM_DATA_W / COLOR_IDX_W;

    logic [COLOR_IDX_W-1:0] nibble [NIBBLES];

    // Nibble 0 sits in the lowest bits of the word.
    for (genvar g = 0; g < NIBBLES; g++) begin : g_split
        assign nibble[g] = i_sram_data[g*COLOR_IDX_W +: COLOR_IDX_W];
    end

    assign o_color_idx = nibble[i_sel];

endmodule

// File: color_decoder.sv
`timescale 1ns/1ps

module color_decoder
    import frame_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  object_id_t             i_object,
    input  logic [COLOR_IDX_W-1:0] i_color_idx,
    output logic [COLOR_W-1:0]     o_color
);

    localparam int CH_W = COLOR_W / 3;

    logic [CH_W-1:0]    level;
    logic [COLOR_W-1:0] color_next;

    // Index times 17, so 0..15 spans 0..255.
    assign level = {i_color_idx, i_color_idx};

    always_comb begin
        case (i_object)
            OBJ_CAR1: color_next = {level, {CH_W{1'b0}}, {CH_W{1'b0}}};
            OBJ_CAR2: color_next = {{CH_W{1'b0}}, {CH_W{1'b0}}, level};
            default:  color_next = {level, level, level};
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_color <= '0;
        end else begin
            o_color <= color_next;
        end
    end

endmodule

// File: frame_decoder.sv
`timescale 1ns/1ps

module frame_decoder
    import frame_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_TOTAL  = 800,
    parameter int V_ACTIVE = 480,
    parameter int V_TOTAL  = 525,
    parameter int SYNC_LEN = 96
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic signed [COORD_W-1:0] i_car1_x,
    input  logic signed [COORD_W-1:0] i_car1_y,
    input  logic signed [COORD_W-1:0] i_car2_x,
    input  logic signed [COORD_W-1:0] i_car2_y,
    input  logic [SPRITE_PIX-1:0]     i_car1_mask,
    input  logic [SPRITE_PIX-1:0]     i_car2_mask,
    output logic [SRAM_ADDR_W-1:0]    o_sram_addr,
    input  logic [SRAM_DATA_W-1:0]    i_sram_data,
    output logic [COLOR_W-1:0]        o_color,
    output logic                      o_active,
    output logic                      o_hsync,
    output logic                      o_vsync
);

    logic [COORD_W-1:0]     h_count;
    logic [COORD_W-1:0]     v_count;
    logic                   scan_active;
    logic                   scan_hsync;
    logic                   scan_vsync;
    object_id_t             object;
    object_id_t             object_sram;
    logic [PIX_IDX_W-1:0]   pixel_index;
    logic [SEL_W-1:0]       sel_sram;
    logic [COLOR_IDX_W-1:0] color_idx;

    scan_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .SYNC_LEN (SYNC_LEN)
    ) u_scan_timing (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .o_h_count (h_count),
        .o_v_count (v_count),
        .o_active  (scan_active),
        .o_hsync   (scan_hsync),
        .o_vsync   (scan_vsync)
    );

    pixel_decoder #(
        .H_ACTIVE (H_ACTIVE)
    ) u_pixel_decoder (
        .i_h_count     (h_count),
        .i_v_count     (v_count),
        .i_car1_x      (i_car1_x),
        .i_car1_y      (i_car1_y),
        .i_car2_x      (i_car2_x),
        .i_car2_y      (i_car2_y),
        .i_car1_mask   (i_car1_mask),
        .i_car2_mask   (i_car2_mask),
        .o_object      (object),
        .o_pixel_index (pixel_index)
    );

    sram_addr_encoder u_sram_addr_encoder (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_object      (object),
        .i_pixel_index (pixel_index),
        .o_sram_addr   (o_sram_addr)
    );

    // Address register plus SRAM latency.
    delay_line #(
        .T     (object_id_t),
        .DEPTH (2)
    ) u_object_delay (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_d     (object),
        .o_q     (object_sram)
    );

    delay_line #(
        .T     (logic [SEL_W-1:0]),
        .DEPTH (2)
    ) u_sel_delay (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_d     (pixel_index[SEL_W-1:0]),
        .o_q     (sel_sram)
    );

    // Flags follow the colour through all three register stages.
    delay_line #(
        .T     (logic [2:0]),
        .DEPTH (3)
    ) u_sync_delay (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_d     ({scan_active, scan_hsync, scan_vsync}),
        .o_q     ({o_active, o_hsync, o_vsync})
    );

    sram_data_decoder u_sram_data_decoder (
        .i_sram_data (i_sram_data),
        .i_sel       (sel_sram),
        .o_color_idx (color_idx)
    );

    color_decoder u_color_decoder (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_object    (object_sram),
        .i_color_idx (color_idx),
        .o_color     (o_color)
    );

endmodule

// File: tb_frame_decoder.sv
`timescale 1ns/1ps

module tb_frame_decoder;
    import frame_pkg::*;

    localparam int H_ACTIVE     = 32;
    localparam int H_TOTAL      = 40;
    localparam int V_ACTIVE     = 16;
    localparam int V_TOTAL      = 18;
    localparam int SYNC_LEN     = 4;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES;
    localparam int NUM_SCENES   = 6;
    localparam int MEM_WORDS    = 2048;

    typedef struct packed {
        logic signed [COORD_W-1:0] car1_x;
        logic signed [COORD_W-1:0] car1_y;
        logic signed [COORD_W-1:0] car2_x;
        logic signed [COORD_W-1:0] car2_y;
        logic [SPRITE_PIX-1:0]     car1_mask;
        logic [SPRITE_PIX-1:0]     car2_mask;
    } scene_t;

    // Car 1 x, y, car 2 x, y, then masks; a set bit is transparent.
    localparam scene_t SCENES [NUM_SCENES] = '{
        '{10'sd4, 10'sd2, 10'sd20, 10'sd6, 64'hAA55_AA55_AA55_AA55, 64'h0F0F_F0F0_0F0F_F0F0},
        '{10'sd10, 10'sd4, 10'sd13, 10'sd6, 64'h8421_1248_8421_1248, 64'h0},
        '{-10'sd3, -10'sd2, -10'sd6, 10'sd12, 64'h0, 64'hF0F0_0F0F_F0F0_0F0F},
        '{10'sd28, 10'sd9, 10'sd36, 10'sd3, 64'h0, 64'h0},
        '{10'sd8, 10'sd8, 10'sd12, 10'sd4, {64{1'b1}}, {64{1'b1}}},
        '{10'sd16, 10'sd8, 10'sd20, 10'sd10, 64'h0, 64'h0}
    };

    logic                      clk;
    logic                      rst_n;
    logic signed [COORD_W-1:0] car1_x;
    logic signed [COORD_W-1:0] car1_y;
    logic signed [COORD_W-1:0] car2_x;
    logic signed [COORD_W-1:0] car2_y;
    logic [SPRITE_PIX-1:0]     car1_mask;
    logic [SPRITE_PIX-1:0]     car2_mask;
    logic [SRAM_ADDR_W-1:0]    sram_addr;
    logic [SRAM_DATA_W-1:0]    sram_data = '0;
    logic [COLOR_W-1:0]        color;
    logic                      active;
    logic                      hsync;
    logic                      vsync;

    logic [SRAM_DATA_W-1:0] mem [MEM_WORDS];
    int                     errors;
    int                     pixels_checked;
    bit                     timed_out;

    frame_decoder #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .SYNC_LEN (SYNC_LEN)
    ) dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_car1_x    (car1_x),
        .i_car1_y    (car1_y),
        .i_car2_x    (car2_x),
        .i_car2_y    (car2_y),
        .i_car1_mask (car1_mask),
        .i_car2_mask (car2_mask),
        .o_sram_addr (sram_addr),
        .i_sram_data (sram_data),
        .o_color     (color),
        .o_active    (active),
        .o_hsync     (hsync),
        .o_vsync     (vsync)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // External SRAM, one cycle read latency.
    always @(posedge clk) begin
        sram_data <= mem[sram_addr[10:0]];
    end

    function automatic logic opaque_at(input int x, input int y, input int cx, input int cy,
                                       input logic [SPRITE_PIX-1:0] mask);
        int local_idx;
        if (x < cx || x >= cx + SPRITE_SIZE || y < cy || y >= cy + SPRITE_SIZE) begin
            return 1'b0;
        end
        local_idx = (y - cy) * SPRITE_SIZE + (x - cx);
        return !mask[6'(local_idx)];
    endfunction

    function automatic logic [COLOR_W-1:0] expected_color(input int x, input int y);
        object_id_t  owner;
        int          index;
        int          base;
        logic [10:0] word_addr;
        logic [3:0]  nibble;
        logic [7:0]  level;
        owner = OBJ_MAP;
        index = (y >> TILE_SHIFT) * (H_ACTIVE >> TILE_SHIFT) + (x >> TILE_SHIFT);
        base  = MAP_BASE;
        if (opaque_at(x, y, int'(car1_x), int'(car1_y), car1_mask)) begin
            owner = OBJ_CAR1;
            index = (y - int'(car1_y)) * SPRITE_SIZE + (x - int'(car1_x));
            base  = CAR1_BASE;
        end else if (opaque_at(x, y, int'(car2_x), int'(car2_y), car2_mask)) begin
            owner = OBJ_CAR2;
            index = (y - int'(car2_y)) * SPRITE_SIZE + (x - int'(car2_x));
            base  = CAR2_BASE;
        end
        word_addr = 11'(base + index / 4);
        nibble    = 4'(mem[word_addr] >> (4 * (index % 4)));
        level     = 8'(int'(nibble) * 17);
        case (owner)
            OBJ_CAR1: return {level, 8'h00, 8'h00};
            OBJ_CAR2: return {8'h00, 8'h00, level};
            default:  return {level, level, level};
        endcase
    endfunction

    task automatic check_equal(input string name, input int got, input int expected);
        assert (got == expected) else begin
            $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic check_color(input int x, input int y);
        logic [COLOR_W-1:0] expected;
        expected = expected_color(x, y);
        pixels_checked++;
        assert (color === expected) else begin
            $display("Mismatch at %0t ns: o_color at (%0d,%0d) got %06h expected %06h",
                     $time, x, y, color, expected);
            errors++;
        end
    endtask

    task automatic apply_scene(input scene_t sc);
        car1_x    <= sc.car1_x;
        car1_y    <= sc.car1_y;
        car2_x    <= sc.car2_x;
        car2_y    <= sc.car2_y;
        car1_mask <= sc.car1_mask;
        car2_mask <= sc.car2_mask;
    endtask

    // Returns on the falling edge where o_vsync is high.
    task automatic wait_vsync_high();
        int cycles;
        cycles = 0;
        while (!vsync && !timed_out) begin
            @(negedge clk);
            cycles++;
            assert (cycles <= WAIT_LIMIT) else begin
                $display("Timeout at %0t ns: o_vsync never went high", $time);
                timed_out = 1'b1;
                errors++;
            end
        end
    endtask

    // Walks one frame period, starting on the first vsync cycle.
    task automatic check_frame(input logic start_hsync);
        int   frame_cycles;
        int   vsync_cycles;
        int   hsync_cycles;
        int   count;
        int   run;
        logic prev_vsync;
        logic done;
        frame_cycles = 1;
        vsync_cycles = 1;
        hsync_cycles = int'(start_hsync);
        count        = 0;
        run          = 0;
        prev_vsync   = 1'b1;
        done         = 1'b0;
        while (!done && !timed_out) begin
            @(negedge clk);
            if (vsync && !prev_vsync) begin
                done = 1'b1;
            end else begin
                frame_cycles++;
                vsync_cycles += int'(vsync);
                hsync_cycles += int'(hsync);
                if (active) begin
                    check_color(count % H_ACTIVE, count / H_ACTIVE);
                    count++;
                    run++;
                end else if (run != 0) begin
                    check_equal("o_active pixels in line", run, H_ACTIVE);
                    run = 0;
                end
                prev_vsync = vsync;
                assert (frame_cycles <= WAIT_LIMIT) else begin
                    $display("Timeout at %0t ns: frame did not end with a vsync pulse", $time);
                    timed_out = 1'b1;
                    errors++;
                end
            end
        end
        check_equal("frame length", frame_cycles, FRAME_CYCLES);
        check_equal("o_vsync high cycles", vsync_cycles, H_TOTAL);
        check_equal("o_hsync high cycles", hsync_cycles, SYNC_LEN * V_TOTAL);
        check_equal("o_active pixels in frame", count, H_ACTIVE * V_ACTIVE);
    endtask

    initial begin
        logic start_hsync;
        errors         = 0;
        pixels_checked = 0;
        timed_out      = 1'b0;
        rst_n     <= 1'b0;
        car1_x    <= '0;
        car1_y    <= '0;
        car2_x    <= '0;
        car2_y    <= '0;
        car1_mask <= '1;
        car2_mask <= '1;
        void'($urandom(32'hb0db));
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[11'(a)] = 16'($urandom);
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_equal("o_active after reset", int'(active), 0);
        check_equal("o_hsync after reset", int'(hsync), 0);
        check_equal("o_vsync after reset", int'(vsync), 0);
        for (int s = 0; s < NUM_SCENES && !timed_out; s++) begin
            wait_vsync_high();
            if (!timed_out) begin
                start_hsync = hsync;
                check_equal("o_active during vsync", int'(active), 0);
                @(posedge clk);
                apply_scene(SCENES[s]);
                check_frame(start_hsync);
            end
        end
        $display("Checked %0d pixels, %0d errors", pixels_checked, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: project.f
frame_pkg.sv
delay_line.sv
scan_timing.sv
pixel_decoder.sv
sram_addr_encoder.sv
sram_data_decoder.sv
color_decoder.sv
frame_decoder.sv
tb_frame_decoder.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   ?= project.f
TOP        ?= tb_frame_decoder
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  ?= No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
